/* verilog/evm_defines.svh */
// event packet monitor constants
// beat layout, event ids, record length and queue sizing
`ifndef EVM_DEFINES_SVH
`define EVM_DEFINES_SVH

// ----------------------------------------------------------------------
// packet beat layout
// ----------------------------------------------------------------------
`define EVM_BEAT_W      72
`define EVM_SID_LSB     44
`define EVM_SID_W       4
`define EVM_TID_BIT     48
// payload bits carried into the record
`define EVM_PAYLOAD_W   64

// source ids that mark an event packet
`define EVM_SID_EVT_A   4'hE
`define EVM_SID_EVT_B   4'hF

// ----------------------------------------------------------------------
// event fields
// ----------------------------------------------------------------------
`define EVM_ERX_W       4
`define EVM_EID_W       4
// every accepted event is raised with this id
`define EVM_EID_EVENT   4'd4

// record bytes on the wrx bus
`define EVM_REC_BYTES   9

// pending events per thread
`define EVM_QUEUE_DEPTH 4

`endif

/* verilog/evm_pkg.sv */
// event packet monitor types
// beat views, event entry and wrx bus byte
`default_nettype none

`include "evm_defines.svh"

package evm_pkg;

    // ------------------------------------------------------------------
    // header view of a beat
    // ------------------------------------------------------------------
    typedef struct packed {
        // bits above the thread id
        logic [`EVM_BEAT_W-`EVM_TID_BIT-2:0]              upper;
        logic                                             tid;
        logic [`EVM_SID_W-1:0]                            sid;
        // rest of the header, not decoded here
        logic [`EVM_SID_LSB-1:0]                          lower;
    } evm_hdr_t;

    // header beats decode by field, payload beats go raw
    typedef union packed {
        evm_hdr_t                 hdr;
        logic [`EVM_BEAT_W-1:0]   raw;
    } evm_beat_u;

    // ------------------------------------------------------------------
    // event entry, queue and initiator
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [`EVM_ERX_W-1:0]    erx;
        logic [`EVM_EID_W-1:0]    eid;
    } evm_evt_t;

    // one byte on the event register bus
    typedef struct packed {
        logic                     valid;
        logic [7:0]               data;
    } evm_wrx_t;

endpackage

`default_nettype wire

/* verilog/evm_pkt_detect.sv */
// event packet detector
// flags headers with an event sid, strobes the payload beat after it
`default_nettype none
`timescale 1ns/1ps

`include "evm_defines.svh"

module evm_pkt_detect
    import evm_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       i_stb,
    input  wire logic                       i_sof,
    input  wire evm_beat_u                  i_beat,
    output logic                            o_payload_stb,
    output logic                            o_tid,
    output logic [`EVM_PAYLOAD_W-1:0]       o_payload
);

    // last beat taken was an event header
    logic evt_pend;
    // thread of that header
    logic pend_tid;
    logic hdr_is_evt;

    // sid compare on the header view
    assign hdr_is_evt = (i_beat.hdr.sid == `EVM_SID_EVT_A) ||
                        (i_beat.hdr.sid == `EVM_SID_EVT_B);

    // ------------------------------------------------------------------
    // header tracking and payload strobe
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            evt_pend      <= 1'b0;
            pend_tid      <= 1'b0;
            o_payload_stb <= 1'b0;
            o_tid         <= 1'b0;
        end
        else if (i_stb && i_sof)
        begin
            // new header, arm only for event sids
            evt_pend      <= hdr_is_evt;
            pend_tid      <= i_beat.hdr.tid;
            o_payload_stb <= 1'b0;
        end
        else if (i_stb)
        begin
            // data beat directly after an event header
            evt_pend      <= 1'b0;
            o_payload_stb <= evt_pend;
            o_tid         <= pend_tid;
        end
        else
        begin
            // idle cycle breaks the header/payload pair
            evt_pend      <= 1'b0;
            o_payload_stb <= 1'b0;
        end
    end

    // payload word, qualified by o_payload_stb
    always_ff @(posedge clk)
    begin
        if (i_stb && !i_sof)
        begin
            o_payload <= i_beat.raw[`EVM_PAYLOAD_W-1:0];
        end
    end

endmodule

`default_nettype wire

/* verilog/evm_reg_writer.sv */
// event register writer
// keeps per-thread erx pointers, streams the nine-byte record on wrx
// and hands the event to the queue of its thread
`default_nettype none
`timescale 1ns/1ps

`include "evm_defines.svh"

module evm_reg_writer
    import evm_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       i_payload_stb,
    input  wire logic                       i_tid,
    input  wire logic [`EVM_PAYLOAD_W-1:0]  i_payload,
    output evm_wrx_t                        o_wrx,
    output logic [1:0]                      o_dispatch_stb,
    output evm_evt_t                        o_dispatch_evt
);

    localparam int REC_W = `EVM_REC_BYTES * 8;
    // zero bits above tid in the last byte
    localparam int PAD_W = 8 - 1 - `EVM_ERX_W;

    // erx pointer per thread
    logic [`EVM_ERX_W-1:0]      erx_ptr [0:1];
    // one bit per byte still to send
    logic [`EVM_REC_BYTES-1:0]  rec_stb;
    logic [REC_W-1:0]           rec_buf;
    logic [`EVM_ERX_W-1:0]      rec_erx;
    logic                       rec_tid;
    logic                       rec_last;

    // byte 8 on the bus this cycle
    assign rec_last = rec_stb[0] & ~rec_stb[1];

    assign o_wrx.valid = rec_stb[0];
    assign o_wrx.data  = rec_buf[7:0];

    // ------------------------------------------------------------------
    // strobe shifter and record thread
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rec_stb <= '0;
            rec_tid <= 1'b0;
        end
        else if (i_payload_stb)
        begin
            // a new payload restarts the record
            rec_stb <= '1;
            rec_tid <= i_tid;
        end
        else
        begin
            rec_stb <= {1'b0, rec_stb[`EVM_REC_BYTES-1:1]};
        end
    end

    // record data, lowest byte first
    always_ff @(posedge clk)
    begin
        if (i_payload_stb)
        begin
            rec_buf <= {{PAD_W{1'b0}}, i_tid, erx_ptr[i_tid], i_payload};
            rec_erx <= erx_ptr[i_tid];
        end
        else
        begin
            rec_buf <= {8'd0, rec_buf[REC_W-1:8]};
        end
    end

    // ------------------------------------------------------------------
    // dispatch and pointer advance
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            erx_ptr[0]     <= '0;
            erx_ptr[1]     <= '0;
            o_dispatch_stb <= 2'b00;
        end
        else
        begin
            o_dispatch_stb <= {rec_last & rec_tid, rec_last & ~rec_tid};
            // wraps modulo 16
            if (rec_last)
            begin
                erx_ptr[rec_tid] <= erx_ptr[rec_tid] + 1'b1;
            end
        end
    end

    // event word, valid with o_dispatch_stb
    always_ff @(posedge clk)
    begin
        if (rec_last)
        begin
            o_dispatch_evt.erx <= rec_erx;
            o_dispatch_evt.eid <= `EVM_EID_EVENT;
        end
    end

endmodule

`default_nettype wire

/* verilog/evm_evt_queue.sv */
// per-thread event queue
// show-ahead circular buffer, full pushes are dropped
`default_nettype none
`timescale 1ns/1ps

`include "evm_defines.svh"

module evm_evt_queue
    import evm_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       i_push,
    input  wire evm_evt_t   i_evt,
    input  wire logic       i_pop,
    output logic            o_not_empty,
    output evm_evt_t        o_head
);

    localparam int DEPTH = `EVM_QUEUE_DEPTH;
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    evm_evt_t           mem [0:DEPTH-1];
    logic [AW-1:0]      wr_ptr;
    logic [AW-1:0]      rd_ptr;
    // entries held
    logic [CW-1:0]      count;
    logic               full;
    logic               do_push;
    logic               do_pop;

    assign full        = (count == CW'(DEPTH));
    assign o_not_empty = (count != '0);
    // head is read straight from the buffer
    assign o_head      = mem[rd_ptr];

    assign do_push = i_push & ~full;
    assign do_pop  = i_pop & o_not_empty;

    // ------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= i_evt;
        end
    end

    // ------------------------------------------------------------------
    // pointers and occupancy
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave count alone
            if (do_push && !do_pop)
            begin
                count <= count + 1'b1;
            end
            else if (do_pop && !do_push)
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/evm_evt_initiator.sv */
// per-thread event initiator
// raises req for the queue head, holds it until ack
`default_nettype none
`timescale 1ns/1ps

`include "evm_defines.svh"

module evm_evt_initiator
    import evm_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               i_ena,
    input  wire logic               i_not_empty,
    input  wire evm_evt_t           i_head,
    input  wire logic               i_ack,
    output logic                    o_pop,
    output logic                    o_req,
    output logic [`EVM_ERX_W-1:0]   o_erx,
    output logic [`EVM_EID_W-1:0]   o_eid
);

    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_WAIT = 1'b1;

    logic state;

    assign o_req = (state == ST_WAIT);
    // the acknowledged entry leaves the queue
    assign o_pop = o_req & i_ack;

    // ------------------------------------------------------------------
    // request FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    // enable only gates a new request
                    if (i_ena && i_not_empty)
                    begin
                        state <= ST_WAIT;
                    end
                end
                default:
                begin
                    // back to idle for at least a cycle
                    if (i_ack)
                    begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // request fields, frozen while req is high
    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && i_ena && i_not_empty)
        begin
            o_erx <= i_head.erx;
            o_eid <= i_head.eid;
        end
    end

endmodule

`default_nettype wire

/* verilog/evm_box.sv */
// event packet monitor top
// detector, record writer and a queue/initiator pair per thread
`default_nettype none
`timescale 1ns/1ps

`include "evm_defines.svh"

module evm_box
    import evm_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       i_epp_stb,
    input  wire logic                       i_epp_sof,
    input  wire evm_beat_u                  i_epp_data,
    input  wire logic [1:0]                 i_sys_event_ena,
    output logic                            o_evt_th0_req,
    output logic [`EVM_ERX_W-1:0]           o_evt_th0_erx,
    output logic [`EVM_EID_W-1:0]           o_evt_th0_eid,
    input  wire logic                       i_evt_th0_ack,
    output logic                            o_evt_th1_req,
    output logic [`EVM_ERX_W-1:0]           o_evt_th1_erx,
    output logic [`EVM_EID_W-1:0]           o_evt_th1_eid,
    input  wire logic                       i_evt_th1_ack,
    output evm_wrx_t                        o_wrx
);

    // detector to writer
    logic                           payload_stb;
    logic                           payload_tid;
    logic [`EVM_PAYLOAD_W-1:0]      payload;
    // writer to queues
    logic [1:0]                     dispatch_stb;
    evm_evt_t                       dispatch_evt;
    // queue/initiator per thread
    logic                           th0_not_empty;
    logic                           th1_not_empty;
    evm_evt_t                       th0_head;
    evm_evt_t                       th1_head;
    logic                           th0_pop;
    logic                           th1_pop;

    // ------------------------------------------------------------------
    // packet side
    // ------------------------------------------------------------------
    evm_pkt_detect u_detect (
        .clk            (clk),
        .rst            (rst),
        .i_stb          (i_epp_stb),
        .i_sof          (i_epp_sof),
        .i_beat         (i_epp_data),
        .o_payload_stb  (payload_stb),
        .o_tid          (payload_tid),
        .o_payload      (payload)
    );

    evm_reg_writer u_writer (
        .clk            (clk),
        .rst            (rst),
        .i_payload_stb  (payload_stb),
        .i_tid          (payload_tid),
        .i_payload      (payload),
        .o_wrx          (o_wrx),
        .o_dispatch_stb (dispatch_stb),
        .o_dispatch_evt (dispatch_evt)
    );

    // ------------------------------------------------------------------
    // thread 0
    // ------------------------------------------------------------------
    evm_evt_queue u_queue_th0 (
        .clk            (clk),
        .rst            (rst),
        .i_push         (dispatch_stb[0]),
        .i_evt          (dispatch_evt),
        .i_pop          (th0_pop),
        .o_not_empty    (th0_not_empty),
        .o_head         (th0_head)
    );

    evm_evt_initiator u_init_th0 (
        .clk            (clk),
        .rst            (rst),
        .i_ena          (i_sys_event_ena[0]),
        .i_not_empty    (th0_not_empty),
        .i_head         (th0_head),
        .i_ack          (i_evt_th0_ack),
        .o_pop          (th0_pop),
        .o_req          (o_evt_th0_req),
        .o_erx          (o_evt_th0_erx),
        .o_eid          (o_evt_th0_eid)
    );

    // ------------------------------------------------------------------
    // thread 1
    // ------------------------------------------------------------------
    evm_evt_queue u_queue_th1 (
        .clk            (clk),
        .rst            (rst),
        .i_push         (dispatch_stb[1]),
        .i_evt          (dispatch_evt),
        .i_pop          (th1_pop),
        .o_not_empty    (th1_not_empty),
        .o_head         (th1_head)
    );

    evm_evt_initiator u_init_th1 (
        .clk            (clk),
        .rst            (rst),
        .i_ena          (i_sys_event_ena[1]),
        .i_not_empty    (th1_not_empty),
        .i_head         (th1_head),
        .i_ack          (i_evt_th1_ack),
        .o_pop          (th1_pop),
        .o_req          (o_evt_th1_req),
        .o_erx          (o_evt_th1_erx),
        .o_eid          (o_evt_th1_eid)
    );

endmodule

`default_nettype wire

/* dv/tb_evm_checker.sv */
// event packet monitor checker
// models detector, record, erx pointers and queues and compares DUT outputs
`default_nettype none
`timescale 1ns/1ps

`include "evm_defines.svh"

module tb_evm_checker
    import evm_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           i_epp_stb,
    input  wire logic           i_epp_sof,
    input  wire evm_beat_u      i_epp_data,
    input  wire logic [1:0]     i_ena,
    input  wire logic [1:0]     i_req,
    input  wire logic [1:0]     i_ack,
    input  wire logic [3:0]     i_th0_erx,
    input  wire logic [3:0]     i_th0_eid,
    input  wire logic [3:0]     i_th1_erx,
    input  wire logic [3:0]     i_th1_eid,
    input  wire evm_wrx_t       i_wrx,
    output logic [15:0]         o_err_data,
    output logic [15:0]         o_err_proto,
    output logic                o_idle
);

    int          cyc;
    logic        pend;
    logic        pend_tid;
    logic [3:0]  erx_ptr [0:1];
    logic [7:0]  exp_bytes [$];
    logic        rec_tid_q [$];
    logic [3:0]  rec_erx_q [$];
    int          next_due;
    int          push_due [0:1];
    logic [3:0]  push_erx [0:1];
    // model queues per thread
    logic [3:0]  q0 [$];
    logic [3:0]  q1 [$];
    logic        prev_req [0:1];
    logic        prev_ack [0:1];
    logic        prev_ena [0:1];
    logic [3:0]  prev_erx [0:1];
    int          stall [0:1];

    task automatic start_record(input logic tid, input logic [63:0] payload);
        int k;
        for (k = 0; k < 8; k++)
        begin
            exp_bytes.push_back(payload[8*k +: 8]);
        end
        exp_bytes.push_back({3'b000, tid, erx_ptr[tid]});
        rec_tid_q.push_back(tid);
        rec_erx_q.push_back(erx_ptr[tid]);
        erx_ptr[tid] = erx_ptr[tid] + 4'd1;
        next_due     = cyc + 2;
    endtask

    // ----------------------------------------------------------------------
    // record bytes on wrx
    // ----------------------------------------------------------------------
    task automatic check_bytes();
        logic last;
        logic t;
        if (exp_bytes.size() != 0 && cyc >= next_due)
        begin
            last = (exp_bytes.size() % `EVM_REC_BYTES == 1);
            if (!i_wrx.valid)
            begin
                $display("record byte missing at cycle %0d", cyc);
                o_err_proto = o_err_proto + 1;
            end
            else if (i_wrx.data !== exp_bytes[0])
            begin
                $display("CHECK FAILED wrx.data exp %h got %h", exp_bytes[0], i_wrx.data);
                o_err_data = o_err_data + 1;
            end
            void'(exp_bytes.pop_front());
            next_due = cyc + 1;
            if (last)
            begin
                // dispatch follows one cycle later and the queue push on the edge after
                t           = rec_tid_q.pop_front();
                push_due[t] = cyc + 1;
                push_erx[t] = rec_erx_q.pop_front();
            end
        end
        else if (i_wrx.valid)
        begin
            $display("wrx byte with no record expected at cycle %0d", cyc);
            o_err_proto = o_err_proto + 1;
        end
    endtask

    // ----------------------------------------------------------------------
    // request handshake and queue model of one thread
    // ----------------------------------------------------------------------
    task automatic check_thread(input int t, input logic [3:0] erx, input logic [3:0] eid);
        int          depth;
        logic        was_full;
        logic [3:0]  front;
        depth    = (t == 0) ? q0.size() : q1.size();
        was_full = (depth >= `EVM_QUEUE_DEPTH);
        if (prev_req[t] && !prev_ack[t] && !i_req[t])
        begin
            $display("thread %0d req dropped without ack", t);
            o_err_proto = o_err_proto + 1;
        end
        if (prev_req[t] && prev_ack[t] && i_req[t])
        begin
            $display("thread %0d req not released after ack", t);
            o_err_proto = o_err_proto + 1;
        end
        if (i_req[t] && !prev_req[t] && !prev_ena[t])
        begin
            $display("thread %0d req raised with enable low", t);
            o_err_proto = o_err_proto + 1;
        end
        if (i_req[t] && prev_req[t] && !prev_ack[t] && erx !== prev_erx[t])
        begin
            $display("CHECK FAILED th%0d_erx held %h got %h", t, prev_erx[t], erx);
            o_err_data = o_err_data + 1;
        end
        if (i_req[t] && depth == 0)
        begin
            $display("thread %0d raised a request nobody expected", t);
            o_err_proto = o_err_proto + 1;
        end
        else if (i_req[t])
        begin
            front = (t == 0) ? q0[0] : q1[0];
            if (erx !== front)
            begin
                $display("CHECK FAILED th%0d_erx exp %h got %h", t, front, erx);
                o_err_data = o_err_data + 1;
            end
            if (eid !== `EVM_EID_EVENT)
            begin
                $display("CHECK FAILED th%0d_eid exp %h got %h", t, `EVM_EID_EVENT, eid);
                o_err_data = o_err_data + 1;
            end
            if (i_ack[t] && t == 0)
            begin
                void'(q0.pop_front());
            end
            else if (i_ack[t])
            begin
                void'(q1.pop_front());
            end
        end
        // push after pop with full judged before the pop
        if (push_due[t] == cyc)
        begin
            if (!was_full && t == 0)
            begin
                q0.push_back(push_erx[t]);
            end
            else if (!was_full)
            begin
                q1.push_back(push_erx[t]);
            end
            push_due[t] = -1;
        end
        // waiting entry with enable high must see req soon
        stall[t] = (depth != 0 && !i_req[t] && i_ena[t]) ? stall[t] + 1 : 0;
        if (stall[t] == 4)
        begin
            $display("thread %0d expected request missing", t);
            o_err_proto = o_err_proto + 1;
        end
        prev_req[t] = i_req[t];
        prev_ack[t] = i_ack[t];
        prev_ena[t] = i_ena[t];
        prev_erx[t] = erx;
    endtask

    initial
    begin
        o_err_data  = '0;
        o_err_proto = '0;
        o_idle      = 1'b0;
    end

    always @(posedge clk)
    begin
        if (rst)
        begin
            cyc = 0;
            pend = 1'b0;
            pend_tid = 1'b0;
            erx_ptr[0] = '0;
            erx_ptr[1] = '0;
            next_due = 0;
            push_due[0] = -1;
            push_due[1] = -1;
            prev_req[0] = 1'b0;
            prev_req[1] = 1'b0;
            prev_ack[0] = 1'b0;
            prev_ack[1] = 1'b0;
            prev_ena[0] = 1'b0;
            prev_ena[1] = 1'b0;
            stall[0] = 0;
            stall[1] = 0;
            o_idle <= 1'b0;
        end
        else
        begin
            cyc = cyc + 1;
            check_bytes();
            // pending header model
            if (i_epp_stb && i_epp_sof)
            begin
                pend     = (i_epp_data.hdr.sid == `EVM_SID_EVT_A) ||
                           (i_epp_data.hdr.sid == `EVM_SID_EVT_B);
                pend_tid = i_epp_data.hdr.tid;
            end
            else if (i_epp_stb)
            begin
                if (pend)
                begin
                    start_record(pend_tid, i_epp_data.raw[63:0]);
                end
                pend = 1'b0;
            end
            else
            begin
                pend = 1'b0;
            end
            check_thread(0, i_th0_erx, i_th0_eid);
            check_thread(1, i_th1_erx, i_th1_eid);
            o_idle <= (exp_bytes.size() == 0) && (push_due[0] < 0) && (push_due[1] < 0) &&
                      (q0.size() == 0) && (q1.size() == 0) && (i_req == 2'b00);
        end
    end

endmodule

`default_nettype wire

/* dv/tb_evm_box.sv */
// testbench top for the event packet monitor
// drives a table of packets, answers requests, bounds the run
`default_nettype none
`timescale 1ns/1ps

`include "evm_defines.svh"

module tb_evm_box
    import evm_pkg::*;
;
    // one table row
    typedef struct packed {
        logic [3:0]   sid;
        logic         tid;
        logic [63:0]  payload;
        // 0 header only, 1 payload follows, 2 idle gap then payload
        logic [1:0]   mode;
        logic [1:0]   ena;
        logic [7:0]   dly0;
        logic [7:0]   dly1;
    } stim_t;

    logic                       clk;
    logic                       rst;
    logic                       epp_stb;
    logic                       epp_sof;
    evm_beat_u                  epp_data;
    logic [1:0]                 sys_ena;
    logic [1:0]                 ack;
    logic [7:0]                 ack_dly [0:1];
    wire  logic [1:0]           req;
    logic [`EVM_ERX_W-1:0]      th0_erx;
    logic [`EVM_EID_W-1:0]      th0_eid;
    logic [`EVM_ERX_W-1:0]      th1_erx;
    logic [`EVM_EID_W-1:0]      th1_eid;
    evm_wrx_t                   wrx;
    logic [15:0]                err_data;
    logic [15:0]                err_proto;
    logic                       chk_idle;
    stim_t                      table_q [$];
    integer                     seed;

    always #2 clk = ~clk;

    evm_box u_dut (
        .clk             (clk),
        .rst             (rst),
        .i_epp_stb       (epp_stb),
        .i_epp_sof       (epp_sof),
        .i_epp_data      (epp_data),
        .i_sys_event_ena (sys_ena),
        .o_evt_th0_req   (req[0]),
        .o_evt_th0_erx   (th0_erx),
        .o_evt_th0_eid   (th0_eid),
        .i_evt_th0_ack   (ack[0]),
        .o_evt_th1_req   (req[1]),
        .o_evt_th1_erx   (th1_erx),
        .o_evt_th1_eid   (th1_eid),
        .i_evt_th1_ack   (ack[1]),
        .o_wrx           (wrx)
    );

    tb_evm_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .i_epp_stb   (epp_stb),
        .i_epp_sof   (epp_sof),
        .i_epp_data  (epp_data),
        .i_ena       (sys_ena),
        .i_req       (req),
        .i_ack       (ack),
        .i_th0_erx   (th0_erx),
        .i_th0_eid   (th0_eid),
        .i_th1_erx   (th1_erx),
        .i_th1_eid   (th1_eid),
        .i_wrx       (wrx),
        .o_err_data  (err_data),
        .o_err_proto (err_proto),
        .o_idle      (chk_idle)
    );

    // ----------------------------------------------------------------------
    // stimulus helpers
    // ----------------------------------------------------------------------
    task automatic add_entry(input logic [3:0] sid, input logic tid, input logic [1:0] mode,
                             input logic [1:0] ena, input logic [7:0] d0, input logic [7:0] d1);
        stim_t e;
        e.sid     = sid;
        e.tid     = tid;
        e.payload = {$random(seed), $random(seed)};
        e.mode    = mode;
        e.ena     = ena;
        e.dly0    = d0;
        e.dly1    = d1;
        table_q.push_back(e);
    endtask

    // random filler around sid and tid
    function automatic evm_beat_u make_header(input logic [3:0] sid, input logic tid);
        logic [95:0] fill;
        evm_beat_u   h;
        fill         = {$random(seed), $random(seed), $random(seed)};
        h.raw        = fill[71:0];
        h.hdr.sid    = sid;
        h.hdr.tid    = tid;
        return h;
    endfunction

    function automatic evm_beat_u make_payload(input logic [63:0] payload);
        logic [31:0] fill;
        evm_beat_u   b;
        fill  = $random(seed);
        b.raw = {fill[7:0], payload};
        return b;
    endfunction

    task automatic build_table();
        int i;
        // basic events, non-event sid, lone header, gap, another non-event
        add_entry(4'hE, 1'b0, 2'd1, 2'b11, 8'd0, 8'd0);
        add_entry(4'hF, 1'b1, 2'd1, 2'b11, 8'd2, 8'd3);
        add_entry(4'h5, 1'b0, 2'd1, 2'b11, 8'd0, 8'd0);
        add_entry(4'hE, 1'b1, 2'd0, 2'b11, 8'd0, 8'd0);
        add_entry(4'hF, 1'b0, 2'd2, 2'b11, 8'd0, 8'd0);
        add_entry(4'h0, 1'b1, 2'd1, 2'b11, 8'd1, 8'd1);
        // thread 1 withheld, then released
        add_entry(4'hE, 1'b1, 2'd1, 2'b01, 8'd1, 8'd1);
        add_entry(4'hF, 1'b1, 2'd1, 2'b01, 8'd1, 8'd1);
        add_entry(4'hE, 1'b1, 2'd1, 2'b01, 8'd1, 8'd1);
        add_entry(4'hE, 1'b0, 2'd1, 2'b11, 8'd1, 8'd0);
        // thread 0 ack held off until its queue overflows
        for (i = 0; i < 6; i++)
        begin
            add_entry(4'hE, 1'b0, 2'd1, 2'b11, 8'd255, 8'd0);
        end
        add_entry(4'hF, 1'b1, 2'd1, 2'b11, 8'd0, 8'd0);
        // long run for erx wrap on both threads
        for (i = 0; i < 24; i++)
        begin
            add_entry((i % 2 == 0) ? 4'hE : 4'hF, (i % 4 < 2), 2'd1, 2'b11,
                      8'(i % 4), 8'(i % 3));
        end
    endtask

    // answers req of one thread after the current delay
    task automatic serve_acks(input int t);
        int cnt;
        forever
        begin
            @(posedge clk);
            if (req[t])
            begin
                cnt = 0;
                // delay is re-read each cycle so a later row can release it
                while (cnt < int'(ack_dly[t]))
                begin
                    @(posedge clk);
                    cnt++;
                end
                ack[t] <= 1'b1;
                @(posedge clk);
                ack[t] <= 1'b0;
            end
        end
    endtask

    task automatic watchdog(input int cycles);
        repeat (cycles) @(posedge clk);
        $display("timeout after %0d cycles, records or requests still outstanding", cycles);
        $display("** FAIL **");
        $finish;
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial
    begin
        stim_t cur;
        int    i;
        clk        = 1'b0;
        rst        = 1'b1;
        epp_stb    = 1'b0;
        epp_sof    = 1'b0;
        epp_data   = '0;
        sys_ena    = 2'b11;
        ack        = 2'b00;
        ack_dly[0] = 8'd0;
        ack_dly[1] = 8'd0;
        seed       = 29316;
        build_table();
        fork
            watchdog(table_q.size() * 12 + 400);
            serve_acks(0);
            serve_acks(1);
        join_none
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        for (i = 0; i < table_q.size(); i++)
        begin
            cur = table_q[i];
            @(posedge clk);
            sys_ena    <= cur.ena;
            ack_dly[0] <= cur.dly0;
            ack_dly[1] <= cur.dly1;
            epp_stb    <= 1'b1;
            epp_sof    <= 1'b1;
            epp_data   <= make_header(cur.sid, cur.tid);
            @(posedge clk);
            epp_sof    <= 1'b0;
            epp_stb    <= (cur.mode == 2'd1);
            epp_data   <= make_payload(cur.payload);
            @(posedge clk);
            // gap case sends payload one cycle late
            epp_stb    <= (cur.mode == 2'd2);
            @(posedge clk);
            epp_stb    <= 1'b0;
            repeat (8) @(posedge clk);
        end
        // drain everything still queued
        sys_ena    <= 2'b11;
        ack_dly[0] <= 8'd0;
        ack_dly[1] <= 8'd0;
        while (!chk_idle) @(posedge clk);
        repeat (5) @(posedge clk);
        $display("errors: data=%0d protocol=%0d", err_data, err_proto);
        if (err_data == 0 && err_proto == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* evm_box.f */
+incdir+verilog
verilog/evm_pkg.sv
verilog/evm_pkt_detect.sv
verilog/evm_reg_writer.sv
verilog/evm_evt_queue.sv
verilog/evm_evt_initiator.sv
verilog/evm_box.sv
dv/tb_evm_checker.sv
dv/tb_evm_box.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the evm_box testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_evm_box -f evm_box.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
